//--- game_link_pkg.sv
package game_link_pkg;

    // one move word as carried over the serial link
    typedef logic [23:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  dir_t;

    // active-low segment pattern, bit 0 is segment a
    typedef logic [6:0]  seg_t;

    // directions as reported by the keyboard decoder
    localparam dir_t DIR_UP    = 2'd0;
    localparam dir_t DIR_DOWN  = 2'd1;
    localparam dir_t DIR_LEFT  = 2'd2;
    localparam dir_t DIR_RIGHT = 2'd3;

    // set 2 make codes for the game keys
    localparam byte_t SC_W     = 8'h1D;
    localparam byte_t SC_S     = 8'h1B;
    localparam byte_t SC_A     = 8'h1C;
    localparam byte_t SC_D     = 8'h23;
    localparam byte_t SC_SPACE = 8'h29;
    localparam byte_t SC_BREAK = 8'hF0;

    // move codes in the low byte of a move word
    localparam byte_t CODE_UP    = 8'd103;
    localparam byte_t CODE_DOWN  = 8'd104;
    localparam byte_t CODE_LEFT  = 8'd102;
    localparam byte_t CODE_RIGHT = 8'd105;
    localparam byte_t CODE_FIRE  = 8'd106;

endpackage

//--- ps2_key_decoder.sv
module ps2_key_decoder (
    input  logic                sys_clk,
    input  logic                rst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output logic                key_valid,
    output game_link_pkg::dir_t key_dir,
    output logic                key_fire,
    output logic                parity_err
);

    logic [1:0]           clk_sync;
    logic [1:0]           data_sync;
    logic                 clk_prev;
    logic                 clk_fall;
    logic [3:0]           bit_cnt;
    logic [9:0]           shift_reg;
    logic [10:0]          frame;
    logic                 frame_end;
    logic                 frame_ok;
    logic                 break_seen;
    game_link_pkg::byte_t code;
    game_link_pkg::dir_t  code_dir;
    logic                 code_hit;
    logic                 code_fire;

    // both lines idle high
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];

    // frame = stop, parity, d7..d0, start with the stop bit still on the line
    assign frame     = {data_sync[1], shift_reg};
    assign frame_end = clk_fall && (bit_cnt == 4'd10);
    assign frame_ok  = ~frame[0] & frame[10] & (^frame[9:1]);
    assign code      = frame[8:1];

    always_comb begin
        code_hit  = 1'b1;
        code_fire = 1'b0;
        code_dir  = game_link_pkg::DIR_UP;
        case (code)
            game_link_pkg::SC_W:     code_dir  = game_link_pkg::DIR_UP;
            game_link_pkg::SC_S:     code_dir  = game_link_pkg::DIR_DOWN;
            game_link_pkg::SC_A:     code_dir  = game_link_pkg::DIR_LEFT;
            game_link_pkg::SC_D:     code_dir  = game_link_pkg::DIR_RIGHT;
            game_link_pkg::SC_SPACE: code_fire = 1'b1;
            default:                 code_hit  = 1'b0;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            bit_cnt    <= 4'd0;
            break_seen <= 1'b0;
            parity_err <= 1'b0;
            key_valid  <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            if (clk_fall)
                bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
            if (frame_end) begin
                if (!frame_ok)
                    parity_err <= 1'b1;
                else if (code == game_link_pkg::SC_BREAK)
                    break_seen <= 1'b1;
                // release of a key, swallow its code
                else if (break_seen)
                    break_seen <= 1'b0;
                else
                    key_valid <= code_hit;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (clk_fall)
            shift_reg <= {data_sync[1], shift_reg[9:1]};
        if (frame_end) begin
            key_dir  <= code_dir;
            key_fire <= code_fire;
        end
    end

endmodule

//--- link_controller.sv
module link_controller (
    input  logic                 sys_clk,
    input  logic                 rst_n,
    input  logic                 key_valid,
    input  game_link_pkg::dir_t  key_dir,
    input  logic                 key_fire,
    output logic                 tx_req,
    output game_link_pkg::word_t tx_word,
    input  logic                 tx_ack,
    input  logic                 rx_valid,
    input  game_link_pkg::word_t rx_word,
    output game_link_pkg::word_t shown_word
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_RELEASE
    } state_t;

    state_t               state;
    game_link_pkg::byte_t seq_cnt;
    game_link_pkg::byte_t key_code;
    game_link_pkg::byte_t pend_code;
    game_link_pkg::byte_t tx_code;
    logic                 pend_valid;
    logic                 send_pend;
    logic                 send_key;
    logic                 load_tx;
    logic                 take_pend;

    // fire wins over any direction
    always_comb begin
        if (key_fire)
            key_code = game_link_pkg::CODE_FIRE;
        else begin
            case (key_dir)
                game_link_pkg::DIR_UP:   key_code = game_link_pkg::CODE_UP;
                game_link_pkg::DIR_DOWN: key_code = game_link_pkg::CODE_DOWN;
                game_link_pkg::DIR_LEFT: key_code = game_link_pkg::CODE_LEFT;
                default:                 key_code = game_link_pkg::CODE_RIGHT;
            endcase
        end
    end

    // older pending event goes out first
    assign send_pend = (state == ST_IDLE) && pend_valid;
    assign send_key  = (state == ST_IDLE) && !pend_valid && key_valid;
    assign load_tx   = send_pend || send_key;
    assign tx_code   = pend_valid ? pend_code : key_code;

    // slot fills while busy, or refills as it drains; a full slot drops the event
    assign take_pend = key_valid && (send_pend || ((state != ST_IDLE) && !pend_valid));

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            tx_req     <= 1'b0;
            seq_cnt    <= '0;
            pend_valid <= 1'b0;
            shown_word <= '0;
        end else begin
            if (rx_valid)
                shown_word <= rx_word;

            if (take_pend)
                pend_valid <= 1'b1;
            else if (send_pend)
                pend_valid <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (load_tx) begin
                        tx_req <= 1'b1;
                        state  <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    if (tx_ack) begin
                        tx_req  <= 1'b0;
                        seq_cnt <= seq_cnt + 8'd1;
                        state   <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    if (!tx_ack)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (take_pend)
            pend_code <= key_code;
        if (load_tx)
            tx_word <= {seq_cnt, 8'h00, tx_code};
    end

endmodule

//--- link_uart_tx.sv
module link_uart_tx #(
    parameter int BAUD_DIV = 8
) (
    input  logic                 sys_clk,
    input  logic                 rst_n,
    input  logic                 tx_req,
    input  game_link_pkg::word_t tx_word,
    output logic                 tx_ack,
    output logic                 txd
);

    localparam int CNT_W = $clog2(BAUD_DIV);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_ACK
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] baud_cnt;
    logic [4:0]       bit_cnt;
    logic [29:0]      frame_sr;
    logic             bit_end;

    assign bit_end = (baud_cnt == CNT_W'(BAUD_DIV - 1));

    // line idles high outside a frame
    assign txd = (state == ST_SEND) ? frame_sr[0] : 1'b1;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            tx_ack   <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (tx_req) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 5'd1;
                        // last stop bit of the third byte
                        if (bit_cnt == 5'd29) begin
                            tx_ack <= 1'b1;
                            state  <= ST_ACK;
                        end
                    end
                end
                ST_ACK: begin
                    if (!tx_req) begin
                        tx_ack <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // three frames of stop, data, start; low byte leaves first
    always_ff @(posedge sys_clk) begin
        if (state == ST_IDLE)
            frame_sr <= {1'b1, tx_word[23:16], 1'b0,
                         1'b1, tx_word[15:8],  1'b0,
                         1'b1, tx_word[7:0],   1'b0};
        else if ((state == ST_SEND) && bit_end)
            frame_sr <= {1'b1, frame_sr[29:1]};
    end

endmodule

//--- link_uart_rx.sv
module link_uart_rx #(
    parameter int BAUD_DIV = 8
) (
    input  logic                 sys_clk,
    input  logic                 rst_n,
    input  logic                 rxd,
    output logic                 rx_valid,
    output game_link_pkg::word_t rx_word,
    output logic                 frame_err
);

    localparam int CNT_W = $clog2(BAUD_DIV);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t               state;
    logic [1:0]           rxd_sync;
    logic                 rxd_s;
    logic [CNT_W-1:0]     baud_cnt;
    logic [2:0]           bit_cnt;
    logic [1:0]           byte_cnt;
    game_link_pkg::byte_t rx_byte;
    logic [15:0]          low_bytes;
    logic                 half_hit;
    logic                 full_hit;
    logic                 stop_hit;

    assign rxd_s    = rxd_sync[1];
    assign half_hit = (baud_cnt == CNT_W'(BAUD_DIV / 2 - 1));
    assign full_hit = (baud_cnt == CNT_W'(BAUD_DIV - 1));
    assign stop_hit = (state == ST_STOP) && full_hit && rxd_s;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            rxd_sync  <= 2'b11;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rx_valid <= 1'b0;
            baud_cnt <= (full_hit || state == ST_IDLE) ? '0 : baud_cnt + 1'b1;
            case (state)
                ST_IDLE: begin
                    if (!rxd_s)
                        state <= ST_START;
                end
                // recheck at mid start bit so a glitch is ignored
                ST_START: begin
                    if (half_hit) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rxd_s ? ST_IDLE : ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (full_hit) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    if (full_hit) begin
                        state <= ST_IDLE;
                        if (!rxd_s) begin
                            frame_err <= 1'b1;
                            byte_cnt  <= '0;
                        end else if (byte_cnt == 2'd2) begin
                            rx_valid <= 1'b1;
                            byte_cnt <= '0;
                        end else
                            byte_cnt <= byte_cnt + 2'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if ((state == ST_DATA) && full_hit)
            rx_byte <= {rxd_s, rx_byte[7:1]};
        if (stop_hit) begin
            if (byte_cnt == 2'd2)
                rx_word <= {rx_byte, low_bytes};
            else
                low_bytes <= {rx_byte, low_bytes[15:8]};
        end
    end

endmodule

//--- hex_display.sv
module hex_display (
    input  game_link_pkg::word_t shown_word,
    output game_link_pkg::seg_t  hex0,
    output game_link_pkg::seg_t  hex1,
    output game_link_pkg::seg_t  hex2,
    output game_link_pkg::seg_t  hex3,
    output game_link_pkg::seg_t  hex4,
    output game_link_pkg::seg_t  hex5
);

    // segment g is the msb, a lit segment is 0
    function automatic game_link_pkg::seg_t seg_of(input logic [3:0] nib);
        case (nib)
            4'h0: seg_of = 7'b1000000;
            4'h1: seg_of = 7'b1111001;
            4'h2: seg_of = 7'b0100100;
            4'h3: seg_of = 7'b0110000;
            4'h4: seg_of = 7'b0011001;
            4'h5: seg_of = 7'b0010010;
            4'h6: seg_of = 7'b0000010;
            4'h7: seg_of = 7'b1111000;
            4'h8: seg_of = 7'b0000000;
            4'h9: seg_of = 7'b0011000;
            4'hA: seg_of = 7'b0001000;
            4'hB: seg_of = 7'b0000011;
            4'hC: seg_of = 7'b1000110;
            4'hD: seg_of = 7'b0100001;
            4'hE: seg_of = 7'b0000110;
            default: seg_of = 7'b0001110;
        endcase
    endfunction

    assign hex0 = seg_of(shown_word[3:0]);
    assign hex1 = seg_of(shown_word[7:4]);
    assign hex2 = seg_of(shown_word[11:8]);
    assign hex3 = seg_of(shown_word[15:12]);
    assign hex4 = seg_of(shown_word[19:16]);
    assign hex5 = seg_of(shown_word[23:20]);

endmodule

//--- game_link_top.sv
module game_link_top #(
    parameter int BAUD_DIV = 8
) (
    input  logic                sys_clk,
    input  logic                rst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    input  logic                rxd,
    output logic                txd,
    output game_link_pkg::seg_t hex0,
    output game_link_pkg::seg_t hex1,
    output game_link_pkg::seg_t hex2,
    output game_link_pkg::seg_t hex3,
    output game_link_pkg::seg_t hex4,
    output game_link_pkg::seg_t hex5,
    output logic                ps2_parity_err,
    output logic                rx_frame_err
);

    logic                 key_valid;
    game_link_pkg::dir_t  key_dir;
    logic                 key_fire;
    logic                 tx_req;
    logic                 tx_ack;
    game_link_pkg::word_t tx_word;
    logic                 rx_valid;
    game_link_pkg::word_t rx_word;
    game_link_pkg::word_t shown_word;

    ps2_key_decoder ps2_key_decoder_i (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .key_valid  (key_valid),
        .key_dir    (key_dir),
        .key_fire   (key_fire),
        .parity_err (ps2_parity_err)
    );

    link_controller link_controller_i (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .key_valid  (key_valid),
        .key_dir    (key_dir),
        .key_fire   (key_fire),
        .tx_req     (tx_req),
        .tx_word    (tx_word),
        .tx_ack     (tx_ack),
        .rx_valid   (rx_valid),
        .rx_word    (rx_word),
        .shown_word (shown_word)
    );

    // both ends of the link run at the same bit rate
    link_uart_tx #(.BAUD_DIV(BAUD_DIV)) link_uart_tx_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .tx_req  (tx_req),
        .tx_word (tx_word),
        .tx_ack  (tx_ack),
        .txd     (txd)
    );

    link_uart_rx #(.BAUD_DIV(BAUD_DIV)) link_uart_rx_i (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .rxd       (rxd),
        .rx_valid  (rx_valid),
        .rx_word   (rx_word),
        .frame_err (rx_frame_err)
    );

    hex_display hex_display_i (
        .shown_word (shown_word),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .hex3       (hex3),
        .hex4       (hex4),
        .hex5       (hex5)
    );

endmodule

//--- game_link_assertions.sv
module game_link_assertions #(
    parameter bit LINE_CHECK = 1'b1
) (
    input  logic                 sys_clk,
    input  logic                 rst_n,
    input  logic                 tx_req,
    input  logic                 tx_ack,
    input  game_link_pkg::word_t tx_word,
    input  logic                 line_level
);
    timeunit 1ns;
    timeprecision 100ps;

    // request stays up until it is acknowledged
    req_held: assert property (@(posedge sys_clk) disable iff (!rst_n)
        tx_req && !tx_ack |=> tx_req)
        else $error("tx_req dropped before tx_ack");

    ack_needs_req: assert property (@(posedge sys_clk) disable iff (!rst_n)
        $rose(tx_ack) |-> tx_req)
        else $error("tx_ack rose without tx_req");

    // ack released one cycle after req falls
    ack_release: assert property (@(posedge sys_clk) disable iff (!rst_n)
        tx_ack && !tx_req |=> !tx_ack)
        else $error("tx_ack held after tx_req fell");

    word_stable: assert property (@(posedge sys_clk) disable iff (!rst_n)
        tx_req && $past(tx_req) |-> $stable(tx_word))
        else $error("tx_word changed while tx_req was high");

    // serial line idles high between requests
    if (LINE_CHECK) begin : g_line
        line_idle: assert property (@(posedge sys_clk) disable iff (!rst_n)
            !tx_req |-> line_level)
            else $error("serial line low with no request");
    end

endmodule

// the controller has no view of the serial line
bind link_controller game_link_assertions #(.LINE_CHECK(1'b0)) ctrl_checks_i (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .tx_req     (tx_req),
    .tx_ack     (tx_ack),
    .tx_word    (tx_word),
    .line_level (1'b1)
);

bind link_uart_tx game_link_assertions tx_checks_i (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .tx_req     (tx_req),
    .tx_ack     (tx_ack),
    .tx_word    (tx_word),
    .line_level (txd)
);

//--- tb_game_link_top.sv
module tb_game_link_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BAUD_DIV = 8;
    localparam int PS2_HALF = 10;
    localparam int TX_WAIT  = 600;

    logic                 sys_clk;
    logic                 rst_n;
    logic                 ps2_clk;
    logic                 ps2_data;
    logic                 rxd;
    logic                 txd;
    game_link_pkg::seg_t  hex0;
    game_link_pkg::seg_t  hex1;
    game_link_pkg::seg_t  hex2;
    game_link_pkg::seg_t  hex3;
    game_link_pkg::seg_t  hex4;
    game_link_pkg::seg_t  hex5;
    logic                 ps2_parity_err;
    logic                 rx_frame_err;
    logic [41:0]          hex_all;
    logic [31:0]          rng_state;
    int                   error_count;
    int                   tests_run;
    int                   tests_bad;
    int                   txd_falls = 0;
    game_link_pkg::byte_t exp_seq;
    game_link_pkg::word_t last_shown;

    game_link_top #(.BAUD_DIV(BAUD_DIV)) game_link_top_i (
        .sys_clk        (sys_clk),
        .rst_n          (rst_n),
        .ps2_clk        (ps2_clk),
        .ps2_data       (ps2_data),
        .rxd            (rxd),
        .txd            (txd),
        .hex0           (hex0),
        .hex1           (hex1),
        .hex2           (hex2),
        .hex3           (hex3),
        .hex4           (hex4),
        .hex5           (hex5),
        .ps2_parity_err (ps2_parity_err),
        .rx_frame_err   (rx_frame_err)
    );

    assign hex_all = {hex5, hex4, hex3, hex2, hex1, hex0};

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    // any start or data low on the line
    always @(negedge txd) txd_falls++;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // keys 0..4 are W, S, A, D, space
    function automatic game_link_pkg::byte_t scan_code_of(input int idx);
        case (idx)
            0:       return game_link_pkg::SC_W;
            1:       return game_link_pkg::SC_S;
            2:       return game_link_pkg::SC_A;
            3:       return game_link_pkg::SC_D;
            default: return game_link_pkg::SC_SPACE;
        endcase
    endfunction

    // up, down, left, right, fire
    function automatic game_link_pkg::byte_t move_code_of(input int idx);
        case (idx)
            0:       return 8'd103;
            1:       return 8'd104;
            2:       return 8'd102;
            3:       return 8'd105;
            default: return 8'd106;
        endcase
    endfunction

    // random code outside the game keys and the break prefix
    function automatic game_link_pkg::byte_t other_code(input logic [31:0] r);
        game_link_pkg::byte_t c;
        c = r[7:0];
        if (c inside {8'h1D, 8'h1B, 8'h1C, 8'h23, 8'h29, 8'hF0})
            c = c ^ 8'h40;
        return c;
    endfunction

    // lit segments as gfedcba before the active-low inversion
    function automatic game_link_pkg::seg_t seg_model(input logic [3:0] nib);
        logic [6:0] lit;
        case (nib)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h67;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    function automatic logic [41:0] expected_display(input game_link_pkg::word_t w);
        logic [41:0] pat;
        for (int d = 0; d < 6; d++)
            pat[d*7 +: 7] = seg_model(w[d*4 +: 4]);
        return pat;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail t=%0t %s: got %0h expected %0h", $time, name, got, exp);
        error_count++;
    endtask

    task automatic end_test(input string name, input int errors_at_start);
        tests_run++;
        if (error_count == errors_at_start)
            $display("test %s: ok", name);
        else begin
            tests_bad++;
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++)
            @(negedge sys_clk);
    endtask

    // device drives data while the clock is high
    task automatic send_ps2_byte(input game_link_pkg::byte_t code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            repeat (PS2_HALF) @(negedge sys_clk);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge sys_clk);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        repeat (4 * PS2_HALF) @(negedge sys_clk);
    endtask

    // the word ends at the byte with the low stop bit
    // bad_byte 3 sends a clean word
    task automatic send_rx_word(input game_link_pkg::word_t w, input int bad_byte);
        logic [9:0] frame;
        rxd = 1'b1;
        repeat (BAUD_DIV) @(negedge sys_clk);
        for (int b = 0; b < 3 && b <= bad_byte; b++) begin
            frame = {(b != bad_byte), w[b*8 +: 8], 1'b0};
            for (int i = 0; i < 10; i++) begin
                rxd = frame[i];
                repeat (BAUD_DIV) @(negedge sys_clk);
            end
        end
        rxd = 1'b1;
    endtask

    // samples each bit near its middle from the first falling edge
    task automatic capture_tx_word(output game_link_pkg::word_t w, output logic ok);
        logic [29:0] bits;
        int          waited;
        ok = 1'b0;
        w = '0;
        waited = 0;
        @(negedge sys_clk);
        while (txd === 1'b1 && waited < TX_WAIT) begin
            @(negedge sys_clk);
            waited++;
        end
        if (txd !== 1'b0) begin
            $display("t=%0t no start bit on txd within %0d cycles", $time, TX_WAIT);
            error_count++;
        end else begin
            repeat (BAUD_DIV / 2) @(negedge sys_clk);
            for (int i = 0; i < 30; i++) begin
                bits[i] = txd;
                if (i < 29)
                    repeat (BAUD_DIV) @(negedge sys_clk);
            end
            ok = 1'b1;
            for (int k = 0; k < 3; k++) begin
                if (bits[k*10] !== 1'b0 || bits[k*10+9] !== 1'b1) begin
                    $display("t=%0t txd byte %0d has a bad start or stop bit", $time, k);
                    error_count++;
                    ok = 1'b0;
                end
            end
            w = {bits[28:21], bits[18:11], bits[8:1]};
        end
    endtask

    task automatic press_key(input int idx, input logic with_release);
        game_link_pkg::word_t got;
        game_link_pkg::word_t exp;
        logic                 ok;
        exp = {exp_seq, 8'h00, move_code_of(idx)};
        fork
            send_ps2_byte(scan_code_of(idx), 1'b0);
            capture_tx_word(got, ok);
        join
        if (ok && got !== exp)
            report_mismatch("txd word", got, exp);
        exp_seq = exp_seq + 8'd1;
        if (with_release) begin
            send_ps2_byte(game_link_pkg::SC_BREAK, 1'b0);
            send_ps2_byte(scan_code_of(idx), 1'b0);
        end
    endtask

    task automatic check_display(input game_link_pkg::word_t w, input int limit);
        logic [41:0] exp;
        int          waited;
        exp = expected_display(w);
        waited = 0;
        while (hex_all !== exp && waited < limit) begin
            @(negedge sys_clk);
            waited++;
        end
        for (int d = 0; d < 6; d++) begin
            if (hex_all[d*7 +: 7] !== exp[d*7 +: 7])
                report_mismatch($sformatf("hex%0d", d), hex_all[d*7 +: 7], exp[d*7 +: 7]);
        end
    endtask

    initial begin
        game_link_pkg::word_t w;
        int                   start_errs;
        int                   falls_before;
        int                   lows;
        rst_n = 1'b0;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        rxd = 1'b1;
        rng_state = 32'd45782;
        error_count = 0;
        tests_run = 0;
        tests_bad = 0;
        exp_seq = 8'd0;
        last_shown = '0;
        repeat (4) @(negedge sys_clk);
        rst_n = 1'b1;

        start_errs = error_count;
        lows = 0;
        for (int i = 0; i < 16 * BAUD_DIV; i++) begin
            @(negedge sys_clk);
            if (txd !== 1'b1)
                lows++;
        end
        if (lows != 0) begin
            $display("t=%0t txd left the idle level after reset", $time);
            error_count++;
        end
        check_display(24'h0, 0);
        if (ps2_parity_err !== 1'b0)
            report_mismatch("ps2_parity_err", ps2_parity_err, 0);
        if (rx_frame_err !== 1'b0)
            report_mismatch("rx_frame_err", rx_frame_err, 0);
        end_test("reset levels", start_errs);

        start_errs = error_count;
        for (int i = 0; i < 40; i++)
            press_key(rand_next() % 5, (rand_next() & 1) != 0);
        end_test("key presses to txd words", start_errs);

        // ignored codes and then one press to confirm the count held
        start_errs = error_count;
        falls_before = txd_falls;
        for (int i = 0; i < 12; i++) begin
            if ((rand_next() & 1) != 0)
                send_ps2_byte(other_code(rand_next()), 1'b0);
            else begin
                send_ps2_byte(game_link_pkg::SC_BREAK, 1'b0);
                send_ps2_byte(scan_code_of(rand_next() % 5), 1'b0);
            end
        end
        idle_cycles(40 * BAUD_DIV);
        if (txd_falls != falls_before) begin
            $display("t=%0t txd became active without a game key press", $time);
            error_count++;
        end
        press_key(rand_next() % 5, 1'b0);
        end_test("ignored scan codes", start_errs);

        start_errs = error_count;
        if (ps2_parity_err !== 1'b0)
            report_mismatch("ps2_parity_err", ps2_parity_err, 0);
        falls_before = txd_falls;
        send_ps2_byte(scan_code_of(rand_next() % 5), 1'b1);
        idle_cycles(40 * BAUD_DIV);
        if (txd_falls != falls_before) begin
            $display("t=%0t txd became active after a bad parity frame", $time);
            error_count++;
        end
        if (ps2_parity_err !== 1'b1)
            report_mismatch("ps2_parity_err", ps2_parity_err, 1);
        press_key(rand_next() % 5, 1'b0);
        end_test("ps2 parity error", start_errs);

        start_errs = error_count;
        for (int i = 0; i < 30; i++) begin
            w = game_link_pkg::word_t'(rand_next());
            send_rx_word(w, 3);
            check_display(w, 2 * BAUD_DIV);
            last_shown = w;
        end
        if (rx_frame_err !== 1'b0)
            report_mismatch("rx_frame_err", rx_frame_err, 0);
        end_test("received words on display", start_errs);

        // the low stop bit moves through all three bytes
        start_errs = error_count;
        for (int i = 0; i < 4; i++) begin
            w = game_link_pkg::word_t'(rand_next());
            send_rx_word(w, i % 3);
            idle_cycles(4 * BAUD_DIV);
            check_display(last_shown, 0);
            if (rx_frame_err !== 1'b1)
                report_mismatch("rx_frame_err", rx_frame_err, 1);
        end
        w = game_link_pkg::word_t'(rand_next());
        send_rx_word(w, 3);
        check_display(w, 2 * BAUD_DIV);
        last_shown = w;
        end_test("serial frame error", start_errs);

        $display("tests run %0d, tests with errors %0d, errors %0d",
                 tests_run, tests_bad, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- game_link_top.f
game_link_pkg.sv
ps2_key_decoder.sv
link_controller.sv
link_uart_tx.sv
link_uart_rx.sv
hex_display.sv
game_link_top.sv
game_link_assertions.sv
tb_game_link_top.sv

//--- Makefile
# Verilator build and run for the game link testbench

VERILATOR ?= verilator
TOP       ?= tb_game_link_top
FILELIST  ?= game_link_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, a crashed run has no pass line
run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
